// ==== verilog/soc_map_pkg.sv ====
package soc_map_pkg;

    // Bus byte address
    typedef logic [31:0] addr_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------

    // Internal RAM runs to the top of memory and echoes every 8 KB
    localparam addr_t RAM_BASE       = 32'hFFFF_0000;

    // GPIO window is 256 bytes
    localparam addr_t GPIO_BASE      = 32'h0300_0000;

    localparam addr_t UART_DATA_ADDR = 32'h0300_0100;
    localparam addr_t UART_STAT_ADDR = 32'h0300_0104;

    // Read data for unmapped addresses
    localparam logic [31:0] UNMAPPED_DATA = 32'hFFFF_FFFF;

    typedef enum logic [2:0] {
        reg_none,
        reg_ram,
        reg_gpio,
        reg_uart_data,
        reg_uart_stat
    } region_e;

    // Word offsets inside the GPIO window
    typedef enum logic [5:0] {
        gpio_led     = 6'd0,
        gpio_vga_scl = 6'd1,
        gpio_vga_sda = 6'd2,
        gpio_usb_rst = 6'd3
    } gpio_reg_e;

endpackage

// ==== verilog/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // ------------------------------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [3:0]          sel;
        soc_map_pkg::addr_t  adr;
        logic [31:0]         dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Board pins driven by the GPIO block
    typedef struct packed {
        logic [2:0] led_n;      // active low
        logic       vga_scl;
        logic       vga_sda_oe;
        logic       usb_rst_n;
    } gpio_pins_t;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_e;

endpackage

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
    input  logic                 clk_rv,
    input  logic                 rst_rv,
    input  soc_bus_pkg::wb_req_t wb_req,
    output soc_bus_pkg::wb_rsp_t wb_rsp,
    output logic                 ram_sel,
    output logic                 gpio_sel,
    output logic                 data_sel,
    output logic                 stat_sel,
    input  logic [31:0]          ram_rdata,
    input  logic [31:0]          gpio_rdata,
    input  logic [31:0]          uart_rdata,
    output logic                 bus_err_irq
);
    import soc_map_pkg::*;

    region_e region_d;
    region_e region_q;
    logic    ack_q;
    logic    start;

    // New access only when the previous one is not in its ack cycle
    assign start = wb_req.cyc && wb_req.stb && !ack_q;

    always_comb begin
        if (wb_req.adr >= RAM_BASE) begin
            region_d = reg_ram;
        end else if (wb_req.adr[31:8] == GPIO_BASE[31:8]) begin
            region_d = reg_gpio;
        end else if (wb_req.adr == UART_DATA_ADDR) begin
            region_d = reg_uart_data;
        end else if (wb_req.adr == UART_STAT_ADDR) begin
            region_d = reg_uart_stat;
        end else begin
            region_d = reg_none;
        end
    end

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            ack_q       <= 1'b0;
            region_q    <= reg_none;
            bus_err_irq <= 1'b0;
        end else begin
            ack_q <= start;
            if (start) begin
                region_q <= region_d;
            end
            // Sticky until reset
            if (start && region_d == reg_none) begin
                bus_err_irq <= 1'b1;
            end
        end
    end

    // Selects are only live in the ack cycle
    assign ram_sel  = ack_q && (region_q == reg_ram);
    assign gpio_sel = ack_q && (region_q == reg_gpio);
    assign data_sel = ack_q && (region_q == reg_uart_data);
    assign stat_sel = ack_q && (region_q == reg_uart_stat);

    always_comb begin
        wb_rsp.ack = ack_q;
        case (region_q)
            reg_ram:       wb_rsp.dat = ram_rdata;
            reg_gpio:      wb_rsp.dat = gpio_rdata;
            reg_uart_data: wb_rsp.dat = uart_rdata;
            reg_uart_stat: wb_rsp.dat = uart_rdata;
            default:       wb_rsp.dat = UNMAPPED_DATA;
        endcase
    end

endmodule

// ==== verilog/boot_ram.sv ====
`timescale 1ns/1ps

module boot_ram #(
    parameter int RAM_WORDS = 2048
) (
    input  logic                 clk_rv,
    input  logic                 ram_sel,
    input  soc_bus_pkg::wb_req_t wb_req,
    output logic [31:0]          ram_rdata
);
    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;

    // Upper address bits are ignored, which makes the window echo
    assign idx = wb_req.adr[AW+1:2];

    always_ff @(posedge clk_rv) begin
        if (ram_sel && wb_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= wb_req.dat[8*b +: 8];
                end
            end
        end
        // Read every cycle so the word is ready by the ack
        ram_rdata <= mem[idx];
    end

endmodule

// ==== verilog/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs (
    input  logic                    clk_rv,
    input  logic                    rst_rv,
    input  logic                    gpio_sel,
    input  soc_bus_pkg::wb_req_t    wb_req,
    input  logic                    vga_sda_in,
    output logic [31:0]             gpio_rdata,
    output soc_bus_pkg::gpio_pins_t gpio_pins
);
    import soc_map_pkg::*;

    gpio_reg_e  offset;
    logic [2:0] led_on;
    logic       vga_scl;
    logic       vga_sda_oe;
    logic       usb_rst_n;

    assign offset = gpio_reg_e'(wb_req.adr[7:2]);

    // ------------------------------------------------------------------------
    // Register writes from the low byte
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            led_on     <= 3'b000;
            vga_scl    <= 1'b1;
            vga_sda_oe <= 1'b0;
            usb_rst_n  <= 1'b0;
        end else if (gpio_sel && wb_req.we && wb_req.sel[0]) begin
            case (offset)
                gpio_led:     led_on     <= wb_req.dat[2:0];
                gpio_vga_scl: vga_scl    <= wb_req.dat[0];
                gpio_vga_sda: vga_sda_oe <= wb_req.dat[0];
                gpio_usb_rst: usb_rst_n  <= wb_req.dat[0];
                default: ;
            endcase
        end
    end

    // SDA read-back comes straight from the pad
    always_comb begin
        case (offset)
            gpio_led:     gpio_rdata = {29'd0, led_on};
            gpio_vga_scl: gpio_rdata = {31'd0, vga_scl};
            gpio_vga_sda: gpio_rdata = {31'd0, vga_sda_in};
            gpio_usb_rst: gpio_rdata = {31'd0, usb_rst_n};
            default:      gpio_rdata = 32'd0;
        endcase
    end

    // LEDs are wired active low on the board
    assign gpio_pins.led_n      = ~led_on;
    assign gpio_pins.vga_scl    = vga_scl;
    assign gpio_pins.vga_sda_oe = vga_sda_oe;
    assign gpio_pins.usb_rst_n  = usb_rst_n;

endmodule

// ==== verilog/uart_tx_port.sv ====
`timescale 1ns/1ps

module uart_tx_port #(
    parameter int CLKS_PER_BIT = 217
) (
    input  logic                 clk_rv,
    input  logic                 rst_rv,
    input  logic                 data_sel,
    input  logic                 stat_sel,
    input  soc_bus_pkg::wb_req_t wb_req,
    output logic [31:0]          uart_rdata,
    output logic                 txd
);
    import soc_bus_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT);

    uart_state_e   state;
    logic [CW-1:0] baud_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          busy;
    logic          bit_end;

    assign busy    = (state != st_idle);
    assign bit_end = (baud_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_idx  <= 3'd0;
            txd      <= 1'b1;
        end else begin
            baud_cnt <= (state == st_idle || bit_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                st_idle: begin
                    // Writes while busy never reach this branch and are dropped
                    if (data_sel && wb_req.we) begin
                        state <= st_start;
                        shift <= wb_req.dat[7:0];
                        txd   <= 1'b0;
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state   <= st_data;
                        bit_idx <= 3'd0;
                        txd     <= shift[0];
                        shift   <= shift >> 1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shift[0];
                            shift   <= shift >> 1;
                        end
                    end
                end
                default: begin
                    // Busy clears as the stop bit ends
                    if (bit_end) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    assign uart_rdata = stat_sel ? {31'd0, busy} : 32'd0;

endmodule

// ==== verilog/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int RESET_HOLD = 63
) (
    input  logic clk_rv,
    input  logic rst_rv,
    input  logic mem_init_done,
    output logic cpu_rst_n
);
    localparam int CW = $clog2(RESET_HOLD + 1);

    logic [CW-1:0] hold_cnt;

    // Count restarts while in reset or before memory init is done
    always_ff @(posedge clk_rv) begin
        if (!rst_rv || !mem_init_done) begin
            hold_cnt  <= '0;
            cpu_rst_n <= 1'b0;
        end else if (hold_cnt == CW'(RESET_HOLD)) begin
            cpu_rst_n <= 1'b1;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
    parameter int RAM_WORDS    = 2048,
    parameter int CLKS_PER_BIT = 217,
    parameter int RESET_HOLD   = 63
) (
    input  logic                    clk_rv,
    input  logic                    rst_rv,
    input  logic                    mem_init_done,
    input  soc_bus_pkg::wb_req_t    wb_req,
    output soc_bus_pkg::wb_rsp_t    wb_rsp,
    input  logic                    vga_sda_in,
    output soc_bus_pkg::gpio_pins_t gpio_pins,
    output logic                    txd,
    output logic                    bus_err_irq,
    output logic                    cpu_rst_n
);
    logic        ram_sel;
    logic        gpio_sel;
    logic        data_sel;
    logic        stat_sel;
    logic [31:0] ram_rdata;
    logic [31:0] gpio_rdata;
    logic [31:0] uart_rdata;

    // ------------------------------------------------------------------------
    // Bus fabric and slaves
    // ------------------------------------------------------------------------
    bus_decoder u_decoder (
        .clk_rv, .rst_rv, .wb_req, .wb_rsp,
        .ram_sel, .gpio_sel, .data_sel, .stat_sel,
        .ram_rdata, .gpio_rdata, .uart_rdata, .bus_err_irq
    );

    boot_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (.clk_rv, .ram_sel, .wb_req, .ram_rdata);

    gpio_regs u_gpio (.clk_rv, .rst_rv, .gpio_sel, .wb_req, .vga_sda_in, .gpio_rdata, .gpio_pins);

    uart_tx_port #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .clk_rv, .rst_rv, .data_sel, .stat_sel, .wb_req, .uart_rdata, .txd
    );

    // CPU reset release
    reset_sequencer #(.RESET_HOLD(RESET_HOLD)) u_rstseq (
        .clk_rv, .rst_rv, .mem_init_done, .cpu_rst_n
    );

endmodule

// ==== tests/soc_checker.sv ====
`timescale 1ns/1ps

module soc_checker #(
    parameter int CLKS_PER_BIT = 8,
    parameter int RESET_HOLD   = 10
) (
    input  logic                    clk_rv,
    input  logic                    rst_rv,
    input  logic                    mem_init_done,
    input  soc_bus_pkg::wb_req_t    wb_req,
    input  soc_bus_pkg::wb_rsp_t    wb_rsp,
    input  soc_bus_pkg::gpio_pins_t gpio_pins,
    input  logic                    txd,
    input  logic                    bus_err_irq,
    input  logic                    cpu_rst_n,
    input  logic [127:0]            exp_name,
    input  logic [1:0]              exp_kind,
    input  logic [31:0]             exp_val,
    input  logic                    exp_irq,
    input  logic                    done,
    output logic                    frame_pending,
    output int                      errors
);
    int           err_cnt = 0;
    int           framing_err = 0;
    int           checks = 0;
    int           rst_cycles = 0;
    int           both_cnt = 0;
    int           stb_cycles = 0;
    int           pend_cycles = 0;
    int           frames_seen = 0;
    int           frames_done = 0;
    logic         prev_ack = 1'b0;
    logic         released = 1'b0;
    logic         irq_seen = 1'b0;
    logic         pins_due = 1'b0;
    logic         done_seen = 1'b0;
    logic [5:0]   pins_exp;
    logic [127:0] pins_name;
    logic [127:0] pend_name;
    logic [7:0]   exp_byte;
    logic [7:0]   rx_byte;

    assign errors = err_cnt + framing_err;

    initial frame_pending = 1'b0;

    task automatic compare(input logic [127:0] name, input logic [31:0] expv,
                           input logic [31:0] act);
        checks++;
        if (expv !== act) begin
            err_cnt++;
            $display("Mismatch %0s: expected %h, actual %h", name, expv, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // UART line decoder sampling near the middle of each bit
    // ------------------------------------------------------------------------
    initial begin
        wait (rst_rv === 1'b1);
        forever begin
            @(negedge txd);
            repeat (CLKS_PER_BIT / 2) @(negedge clk_rv);
            if (txd !== 1'b0) begin
                framing_err++;
                $display("Start bit on txd did not stay low");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk_rv);
                rx_byte[i] = txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_rv);
            if (txd !== 1'b1) begin
                framing_err++;
                $display("Stop bit on txd was low");
            end
            frames_seen++;
        end
    end

    always @(posedge clk_rv) begin
        if (!rst_rv) begin
            rst_cycles++;
            if (rst_cycles == 8) begin
                compare("reset_ack", 32'd0, {31'd0, wb_rsp.ack});
                compare("reset_irq", 32'd0, {31'd0, bus_err_irq});
                compare("reset_txd", 32'd1, {31'd0, txd});
                compare("reset_pins", 32'h3C, {26'd0, gpio_pins});
                compare("reset_cpu_rst_n", 32'd0, {31'd0, cpu_rst_n});
            end
        end else begin
            // Hold count measured from the first edge with both inputs high
            both_cnt = mem_init_done ? both_cnt + 1 : 0;
            if (cpu_rst_n && !released) begin
                released = 1'b1;
                compare("cpu_rst_hold", RESET_HOLD, both_cnt - 2);
            end
            if (irq_seen && !bus_err_irq) begin
                err_cnt++;
                $display("bus_err_irq dropped before reset");
            end
            irq_seen = irq_seen | bus_err_irq;
            if (pins_due) begin
                pins_due = 1'b0;
                compare(pins_name, {26'd0, pins_exp}, {26'd0, gpio_pins});
            end
            if (frames_done != frames_seen) begin
                frames_done = frames_seen;
                if (frame_pending) begin
                    frame_pending = 1'b0;
                    compare(pend_name, {24'd0, exp_byte}, {24'd0, rx_byte});
                end else begin
                    err_cnt++;
                    $display("Unexpected UART frame carrying byte %h", rx_byte);
                end
            end else if (frame_pending) begin
                pend_cycles++;
                if (pend_cycles > 12 * CLKS_PER_BIT) begin
                    err_cnt++;
                    frame_pending = 1'b0;
                    $display("No UART frame appeared on txd for %0s", pend_name);
                end
            end
            if (wb_rsp.ack) begin
                compare("ack_delay", 32'd1, stb_cycles);
                if (prev_ack) begin
                    err_cnt++;
                    $display("Ack for %0s lasted more than one cycle", exp_name);
                end
                compare("bus_err_irq", {31'd0, exp_irq}, {31'd0, bus_err_irq});
                case (exp_kind)
                    2'd1: compare(exp_name, exp_val, wb_rsp.dat);
                    2'd2: begin
                        pins_due  = 1'b1;
                        pins_exp  = exp_val[5:0];
                        pins_name = exp_name;
                    end
                    2'd3: begin
                        frame_pending = 1'b1;
                        pend_cycles   = 0;
                        exp_byte      = exp_val[7:0];
                        pend_name     = exp_name;
                    end
                    default: ;
                endcase
            end
            if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
                stb_cycles++;
                if (stb_cycles == 4) begin
                    err_cnt++;
                    $display("No ack came for %0s", exp_name);
                end
            end else if (!wb_req.stb) begin
                stb_cycles = 0;
            end
            prev_ack = wb_rsp.ack;
            if (done && !done_seen) begin
                done_seen = 1'b1;
                if (!released) begin
                    err_cnt++;
                    $display("cpu_rst_n was never released");
                end
                $display("Checker: %0d checks, %0d frames, %0d errors, %0d framing errors",
                         checks, frames_seen, err_cnt, framing_err);
            end
        end
    end

endmodule

// ==== tests/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb;
    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int RESET_HOLD   = 10;
    localparam int MAX_CASES    = 64;

    logic         clk_rv;
    logic         rst_rv;
    logic         mem_init_done;
    logic         vga_sda_in;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    gpio_pins_t   gpio_pins;
    logic         txd;
    logic         bus_err_irq;
    logic         cpu_rst_n;
    logic [127:0] exp_name;
    logic [1:0]   exp_kind;
    logic [31:0]  exp_val;
    logic         exp_irq;
    logic         done;
    logic         frame_pending;
    int           errors;
    int           bad_lines = 0;
    int           n_cases = 0;
    logic         loaded = 1'b0;

    // Case table loaded from the cases file
    logic [127:0] c_name [MAX_CASES];
    logic [63:0]  c_op   [MAX_CASES];
    logic [31:0]  c_addr [MAX_CASES];
    logic [3:0]   c_sel  [MAX_CASES];
    logic [31:0]  c_data [MAX_CASES];
    logic [31:0]  c_exp  [MAX_CASES];

    soc_top #(.RAM_WORDS(2048), .CLKS_PER_BIT(CLKS_PER_BIT), .RESET_HOLD(RESET_HOLD)) uut (
        .clk_rv, .rst_rv, .mem_init_done, .wb_req, .wb_rsp,
        .vga_sda_in, .gpio_pins, .txd, .bus_err_irq, .cpu_rst_n
    );

    soc_checker #(.CLKS_PER_BIT(CLKS_PER_BIT), .RESET_HOLD(RESET_HOLD)) u_checker (
        .clk_rv, .rst_rv, .mem_init_done, .wb_req, .wb_rsp, .gpio_pins, .txd,
        .bus_err_irq, .cpu_rst_n, .exp_name, .exp_kind, .exp_val, .exp_irq,
        .done, .frame_pending, .errors
    );

    initial begin
        clk_rv = 1'b0;
        forever #10 clk_rv = ~clk_rv;
    end

    // Inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk_rv);
        #2;
    endtask

    function automatic logic is_mapped(input addr_t adr);
        return adr >= RAM_BASE ||
               (adr >= GPIO_BASE && adr < GPIO_BASE + 32'd256) ||
               adr == UART_DATA_ADDR || adr == UART_STAT_ADDR;
    endfunction

    task automatic access(input logic we, input addr_t adr, input logic [3:0] sel,
                          input logic [31:0] dat);
        int waited;
        waited = 0;
        repeat (1 + $urandom_range(3, 0)) step();
        exp_irq    = exp_irq | !is_mapped(adr);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.sel = sel;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            step();
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        step();
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic run_case(input int i);
        exp_name   = c_name[i];
        vga_sda_in = 1'($urandom);
        if (c_op[i] == "read") begin
            exp_kind = 2'd1;
            // The SDA register reads the pad itself
            exp_val  = (c_addr[i] == GPIO_BASE + 32'd8) ? {31'd0, vga_sda_in} : c_exp[i];
            access(1'b0, c_addr[i], c_sel[i], 32'd0);
        end else if (c_op[i] == "write") begin
            exp_kind = (c_addr[i][31:8] == GPIO_BASE[31:8]) ? 2'd2 : 2'd0;
            exp_val  = c_exp[i];
            access(1'b1, c_addr[i], c_sel[i], c_data[i]);
        end else if (c_op[i] == "uart") begin
            exp_kind = 2'd3;
            exp_val  = c_exp[i];
            access(1'b1, c_addr[i], c_sel[i], c_data[i]);
            exp_kind = 2'd1;
            exp_val  = 32'd1;
            access(1'b0, UART_STAT_ADDR, 4'hF, 32'd0);
            // The second write lands while busy and must be dropped
            exp_kind = 2'd0;
            access(1'b1, UART_DATA_ADDR, 4'hF, ~c_data[i]);
            while (frame_pending) step();
            repeat (2 * CLKS_PER_BIT) step();
            exp_kind = 2'd1;
            exp_val  = 32'd0;
            access(1'b0, UART_STAT_ADDR, 4'hF, 32'd0);
        end else begin
            bad_lines++;
            $display("Unknown operation in case %0s", c_name[i]);
        end
    endtask

    initial begin
        int           fd;
        string        line;
        logic [127:0] nm;
        logic [63:0]  op;
        logic [31:0]  a;
        logic [31:0]  s;
        logic [31:0]  d;
        logic [31:0]  e;
        void'($urandom(66346));
        wb_req        = '0;
        rst_rv        = 1'b0;
        mem_init_done = 1'b0;
        vga_sda_in    = 1'b0;
        done          = 1'b0;
        exp_name      = '0;
        exp_kind      = 2'd0;
        exp_val       = 32'd0;
        exp_irq       = 1'b0;
        fd = $fopen("tests/soc_cases.txt", "r");
        if (fd == 0) begin
            bad_lines++;
            $display("Cannot open tests/soc_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                if ($fgets(line, fd) > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %s %h %h %h %h", nm, op, a, s, d, e) == 6) begin
                    c_name[n_cases] = nm;
                    c_op[n_cases]   = op;
                    c_addr[n_cases] = a;
                    c_sel[n_cases]  = s[3:0];
                    c_data[n_cases] = d;
                    c_exp[n_cases]  = e;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (16) @(posedge clk_rv);
        #2;
        rst_rv = 1'b1;
        // Memory init finishes late
        repeat (5) step();
        mem_init_done = 1'b1;
        while (!cpu_rst_n) step();
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        repeat (4) step();
        done = 1'b1;
        repeat (3) step();
        if (errors == 0 && bad_lines == 0 && n_cases > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (n_cases * (12 * CLKS_PER_BIT + 40) + 16 + 5 + RESET_HOLD + 30) @(posedge clk_rv);
        $display("Watchdog timeout, the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== tests/soc_cases.txt ====
# name op addr sel data expected
# write to GPIO expects pins {led_n, scl, sda_oe, usb_rst_n}; uart expects the byte on txd
ram_full write FFFF0010 F AABBCCDD 0
ram_part write FFFF0010 3 11223344 0
ram_read read FFFF0010 F 0 AABB3344
ram_echo read FFFF2010 F 0 AABB3344
led_wr write 03000000 F 5 14
led_rd read 03000000 F 0 5
scl_wr write 03000004 F 0 10
sda_oe_wr write 03000008 F 1 12
usb_wr write 0300000C F 1 13
sda_rd read 03000008 F 0 0
uart_a5 uart 03000100 F A5 A5
uart_0f uart 03000100 F 0F 0F
unmapped read 10000000 F 0 FFFFFFFF
unmapped_gap read 03000108 F 0 FFFFFFFF
ram_after read FFFF0010 F 0 AABB3344

// ==== flist.f ====
verilog/soc_map_pkg.sv
verilog/soc_bus_pkg.sv
verilog/bus_decoder.sv
verilog/boot_ram.sv
verilog/gpio_regs.sv
verilog/uart_tx_port.sv
verilog/reset_sequencer.sv
verilog/soc_top.sv
tests/soc_checker.sv
tests/soc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST) tests/soc_cases.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
